// File: source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// register index width
`define RV_REG_IDX_W 5

// byte lane bits of an address
`define RV_LANE_W 2

// link increment for jal and jalr
`define RV_PC_STEP 4

`endif

// File: source/rv_pkg.sv
package rv_pkg;

    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluNone    = 4'd0,
        aluAdd     = 4'd1,
        aluSub     = 4'd2,
        aluSll     = 4'd3,
        aluSlt     = 4'd4,
        aluSltu    = 4'd5,
        aluXor     = 4'd6,
        aluSrl     = 4'd7,
        aluSra     = 4'd8,
        aluOr      = 4'd9,
        aluAnd     = 4'd10,
        aluPassImm = 4'd11, // lui
        aluLink    = 4'd12, // pc + step for jal, jalr
        aluAuipc   = 4'd13  // pc + imm
    } aluOpE;

    typedef enum logic [3:0] {
        brNone = 4'd0,
        brJal  = 4'd1,
        brJalr = 4'd2,
        brBeq  = 4'd3,
        brBne  = 4'd4,
        brBlt  = 4'd5,
        brBge  = 4'd6,
        brBltu = 4'd7,
        brBgeu = 4'd8
    } branchOpE;

    typedef enum logic [3:0] {
        memNone = 4'd0,
        memLb   = 4'd1,
        memLh   = 4'd2,
        memLw   = 4'd3,
        memLbu  = 4'd4,
        memLhu  = 4'd5,
        memSb   = 4'd6,
        memSh   = 4'd7,
        memSw   = 4'd8
    } memOpE;

endpackage

// File: source/instDecoder.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module instDecoder (
    input  logic [`RV_XLEN-1:0]      inst,
    output logic [`RV_REG_IDX_W-1:0] rd,
    output logic [`RV_XLEN-1:0]      imm,
    output rv_pkg::aluOpE            aluOp,
    output logic                     aluUseImm,
    output rv_pkg::branchOpE         branchOp,
    output rv_pkg::memOpE            memOp,
    output logic                     rdWriteEn
);

    rv_pkg::opcodeE     opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`RV_XLEN-1:0] immI, immS, immB, immU, immJ;

    assign opcode = rv_pkg::opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm       = '0;
        aluOp     = rv_pkg::aluNone;
        aluUseImm = 1'b0;
        branchOp  = rv_pkg::brNone;
        memOp     = rv_pkg::memNone;
        rdWriteEn = 1'b0;
        case (opcode)
            rv_pkg::opLui: begin
                imm       = immU;
                aluOp     = rv_pkg::aluPassImm;
                aluUseImm = 1'b1;
                rdWriteEn = 1'b1;
            end
            rv_pkg::opAuipc: begin
                imm       = immU;
                aluOp     = rv_pkg::aluAuipc;
                aluUseImm = 1'b1;
                rdWriteEn = 1'b1;
            end
            rv_pkg::opJal: begin
                imm       = immJ;
                aluOp     = rv_pkg::aluLink;
                branchOp  = rv_pkg::brJal;
                rdWriteEn = 1'b1;
            end
            rv_pkg::opJalr: begin
                imm = immI;
                if (funct3 == 3'b000) begin
                    aluOp     = rv_pkg::aluLink;
                    branchOp  = rv_pkg::brJalr;
                    rdWriteEn = 1'b1;
                end
            end
            rv_pkg::opBranch: begin
                imm = immB;
                case (funct3)
                    3'b000:  branchOp = rv_pkg::brBeq;
                    3'b001:  branchOp = rv_pkg::brBne;
                    3'b100:  branchOp = rv_pkg::brBlt;
                    3'b101:  branchOp = rv_pkg::brBge;
                    3'b110:  branchOp = rv_pkg::brBltu;
                    3'b111:  branchOp = rv_pkg::brBgeu;
                    default: branchOp = rv_pkg::brNone;
                endcase
            end
            rv_pkg::opLoad: begin
                imm = immI;
                case (funct3)
                    3'b000:  memOp = rv_pkg::memLb;
                    3'b001:  memOp = rv_pkg::memLh;
                    3'b010:  memOp = rv_pkg::memLw;
                    3'b100:  memOp = rv_pkg::memLbu;
                    3'b101:  memOp = rv_pkg::memLhu;
                    default: memOp = rv_pkg::memNone;
                endcase
                rdWriteEn = (memOp != rv_pkg::memNone);
            end
            rv_pkg::opStore: begin
                imm = immS;
                case (funct3)
                    3'b000:  memOp = rv_pkg::memSb;
                    3'b001:  memOp = rv_pkg::memSh;
                    3'b010:  memOp = rv_pkg::memSw;
                    default: memOp = rv_pkg::memNone;
                endcase
            end
            rv_pkg::opOpImm: begin
                imm       = immI;
                aluUseImm = 1'b1;
                case (funct3)
                    3'b000: aluOp = rv_pkg::aluAdd;
                    3'b010: aluOp = rv_pkg::aluSlt;
                    3'b011: aluOp = rv_pkg::aluSltu;
                    3'b100: aluOp = rv_pkg::aluXor;
                    3'b110: aluOp = rv_pkg::aluOr;
                    3'b111: aluOp = rv_pkg::aluAnd;
                    3'b001: aluOp = (funct7 == 7'h00) ? rv_pkg::aluSll : rv_pkg::aluNone;
                    default: begin // 101, srli or srai
                        if (funct7 == 7'h00) begin
                            aluOp = rv_pkg::aluSrl;
                        end else if (funct7 == 7'h20) begin
                            aluOp = rv_pkg::aluSra;
                        end
                    end
                endcase
                aluUseImm = (aluOp != rv_pkg::aluNone);
                rdWriteEn = (aluOp != rv_pkg::aluNone);
            end
            rv_pkg::opOp: begin
                case ({funct7, funct3})
                    10'b0000000_000: aluOp = rv_pkg::aluAdd;
                    10'b0100000_000: aluOp = rv_pkg::aluSub;
                    10'b0000000_001: aluOp = rv_pkg::aluSll;
                    10'b0000000_010: aluOp = rv_pkg::aluSlt;
                    10'b0000000_011: aluOp = rv_pkg::aluSltu;
                    10'b0000000_100: aluOp = rv_pkg::aluXor;
                    10'b0000000_101: aluOp = rv_pkg::aluSrl;
                    10'b0100000_101: aluOp = rv_pkg::aluSra;
                    10'b0000000_110: aluOp = rv_pkg::aluOr;
                    10'b0000000_111: aluOp = rv_pkg::aluAnd;
                    default:         aluOp = rv_pkg::aluNone; // mul/div land here too
                endcase
                rdWriteEn = (aluOp != rv_pkg::aluNone);
            end
            default: begin
                imm = '0; // unsupported opcode
            end
        endcase
    end

endmodule

// File: source/branchUnit.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module branchUnit (
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1Data,
    input  logic [`RV_XLEN-1:0] rs2Data,
    input  logic [`RV_XLEN-1:0] imm,
    input  rv_pkg::branchOpE    branchOp,
    output logic                jumpEn,
    output logic [`RV_XLEN-1:0] jumpAddr
);

    logic [`RV_XLEN-1:0] pcTarget;
    logic [`RV_XLEN-1:0] regTarget;
    logic                isEqual;
    logic                ltSigned;
    logic                ltUnsigned;

    assign pcTarget   = pc + imm;
    assign regTarget  = (rs1Data + imm) & ~`RV_XLEN'(1); // jalr clears bit 0
    assign isEqual    = (rs1Data == rs2Data);
    assign ltSigned   = ($signed(rs1Data) < $signed(rs2Data));
    assign ltUnsigned = (rs1Data < rs2Data);

    always_comb begin
        jumpEn   = 1'b0;
        jumpAddr = pcTarget;
        case (branchOp)
            rv_pkg::brJal: begin
                jumpEn = 1'b1;
            end
            rv_pkg::brJalr: begin
                jumpEn   = 1'b1;
                jumpAddr = regTarget;
            end
            rv_pkg::brBeq: begin
                jumpEn = isEqual;
            end
            rv_pkg::brBne: begin
                jumpEn = ~isEqual;
            end
            rv_pkg::brBlt: begin
                jumpEn = ltSigned;
            end
            rv_pkg::brBge: begin
                jumpEn = ~ltSigned;
            end
            rv_pkg::brBltu: begin
                jumpEn = ltUnsigned;
            end
            rv_pkg::brBgeu: begin
                jumpEn = ~ltUnsigned;
            end
            default: begin
                jumpAddr = '0; // no branch
            end
        endcase
    end

endmodule

// File: source/intAlu.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module intAlu (
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1Data,
    input  logic [`RV_XLEN-1:0] rs2Data,
    input  logic [`RV_XLEN-1:0] imm,
    input  rv_pkg::aluOpE       aluOp,
    input  logic                aluUseImm,
    output logic [`RV_XLEN-1:0] aluResult
);

    logic [`RV_XLEN-1:0] operandB;
    logic [4:0]          shamt;
    logic                ltSigned;
    logic                ltUnsigned;

    assign operandB   = aluUseImm ? imm : rs2Data;
    assign shamt      = operandB[4:0]; // low five bits only
    assign ltSigned   = ($signed(rs1Data) < $signed(operandB));
    assign ltUnsigned = (rs1Data < operandB);

    always_comb begin
        case (aluOp)
            rv_pkg::aluAdd: begin
                aluResult = rs1Data + operandB;
            end
            rv_pkg::aluSub: begin
                aluResult = rs1Data - operandB;
            end
            rv_pkg::aluSll: begin
                aluResult = rs1Data << shamt;
            end
            rv_pkg::aluSlt: begin
                aluResult = {{(`RV_XLEN-1){1'b0}}, ltSigned};
            end
            rv_pkg::aluSltu: begin
                aluResult = {{(`RV_XLEN-1){1'b0}}, ltUnsigned};
            end
            rv_pkg::aluXor: begin
                aluResult = rs1Data ^ operandB;
            end
            rv_pkg::aluSrl: begin
                aluResult = rs1Data >> shamt;
            end
            rv_pkg::aluSra: begin
                aluResult = $unsigned($signed(rs1Data) >>> shamt);
            end
            rv_pkg::aluOr: begin
                aluResult = rs1Data | operandB;
            end
            rv_pkg::aluAnd: begin
                aluResult = rs1Data & operandB;
            end
            rv_pkg::aluPassImm: begin
                aluResult = operandB; // lui
            end
            rv_pkg::aluLink: begin
                aluResult = pc + `RV_XLEN'(`RV_PC_STEP);
            end
            rv_pkg::aluAuipc: begin
                aluResult = pc + operandB;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

// File: source/loadStoreUnit.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module loadStoreUnit (
    input  logic [`RV_XLEN-1:0] rs1Data,
    input  logic [`RV_XLEN-1:0] rs2Data,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] busReadData,
    input  rv_pkg::memOpE       memOp,
    output logic [`RV_XLEN-1:0] busAddr,
    output logic                busWriteEn,
    output logic [`RV_XLEN-1:0] busWriteData,
    output logic                loadEn,
    output logic [`RV_XLEN-1:0] loadData
);

    logic [`RV_LANE_W-1:0] lane;
    logic [7:0]            laneByte;
    logic [15:0]           laneHalf;

    assign busAddr = (memOp == rv_pkg::memNone) ? '0 : rs1Data + imm;
    assign lane    = busAddr[`RV_LANE_W-1:0];

    // byte and half picked out of the read word
    always_comb begin
        case (lane)
            2'd0:    laneByte = busReadData[7:0];
            2'd1:    laneByte = busReadData[15:8];
            2'd2:    laneByte = busReadData[23:16];
            default: laneByte = busReadData[31:24];
        endcase
        laneHalf = (lane == 2'd0) ? busReadData[15:0] : busReadData[31:16];
    end

    always_comb begin
        busWriteEn   = 1'b1;
        busWriteData = busReadData;
        case (memOp)
            rv_pkg::memSb: begin
                case (lane)
                    2'd0:    busWriteData[7:0]   = rs2Data[7:0];
                    2'd1:    busWriteData[15:8]  = rs2Data[7:0];
                    2'd2:    busWriteData[23:16] = rs2Data[7:0];
                    default: busWriteData[31:24] = rs2Data[7:0];
                endcase
            end
            rv_pkg::memSh: begin
                if (lane == 2'd0) begin
                    busWriteData[15:0] = rs2Data[15:0];
                end else begin
                    busWriteData[31:16] = rs2Data[15:0]; // any other lane, upper half
                end
            end
            rv_pkg::memSw: begin
                busWriteData = rs2Data;
            end
            default: begin
                busWriteEn   = 1'b0;
                busWriteData = '0;
            end
        endcase
    end

    always_comb begin
        loadEn = 1'b1;
        case (memOp)
            rv_pkg::memLb:  loadData = {{(`RV_XLEN-8){laneByte[7]}}, laneByte};
            rv_pkg::memLh:  loadData = {{(`RV_XLEN-16){laneHalf[15]}}, laneHalf};
            rv_pkg::memLw:  loadData = busReadData;
            rv_pkg::memLbu: loadData = {{(`RV_XLEN-8){1'b0}}, laneByte};
            rv_pkg::memLhu: loadData = {{(`RV_XLEN-16){1'b0}}, laneHalf};
            default: begin
                loadEn   = 1'b0;
                loadData = '0;
            end
        endcase
    end

endmodule

// File: source/idExStage.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module idExStage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     inValid,
    output logic                     inReady,
    input  logic [`RV_XLEN-1:0]      pc,
    input  logic [`RV_XLEN-1:0]      inst,
    input  logic [`RV_XLEN-1:0]      rs1Data,
    input  logic [`RV_XLEN-1:0]      rs2Data,
    input  logic [`RV_XLEN-1:0]      busReadData,
    output logic                     outValid,
    input  logic                     outReady,
    output logic                     rdWriteEn,
    output logic [`RV_REG_IDX_W-1:0] rd,
    output logic [`RV_XLEN-1:0]      rdData,
    output logic                     jumpEn,
    output logic [`RV_XLEN-1:0]      jumpAddr,
    output logic                     busWriteEn,
    output logic [`RV_XLEN-1:0]      busAddr,
    output logic [`RV_XLEN-1:0]      busWriteData
);

    logic [`RV_REG_IDX_W-1:0] decRd;
    logic [`RV_XLEN-1:0]      imm;
    rv_pkg::aluOpE            aluOp;
    logic                     aluUseImm;
    rv_pkg::branchOpE         branchOp;
    rv_pkg::memOpE            memOp;
    logic                     decRdWriteEn;
    logic                     nextJumpEn;
    logic [`RV_XLEN-1:0]      nextJumpAddr;
    logic [`RV_XLEN-1:0]      aluResult;
    logic [`RV_XLEN-1:0]      nextBusAddr;
    logic                     nextBusWriteEn;
    logic [`RV_XLEN-1:0]      nextBusWriteData;
    logic                     loadEn;
    logic [`RV_XLEN-1:0]      loadData;
    logic [`RV_XLEN-1:0]      nextRdData;
    logic                     accept;

    assign inReady = ~outValid | outReady; // slot free or draining this edge
    assign accept  = inValid & inReady;

    instDecoder u_instDecoder (
        .inst      (inst),
        .rd        (decRd),
        .imm       (imm),
        .aluOp     (aluOp),
        .aluUseImm (aluUseImm),
        .branchOp  (branchOp),
        .memOp     (memOp),
        .rdWriteEn (decRdWriteEn)
    );

    branchUnit u_branchUnit (
        .pc       (pc),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .imm      (imm),
        .branchOp (branchOp),
        .jumpEn   (nextJumpEn),
        .jumpAddr (nextJumpAddr)
    );

    intAlu u_intAlu (
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .aluOp     (aluOp),
        .aluUseImm (aluUseImm),
        .aluResult (aluResult)
    );

    loadStoreUnit u_loadStoreUnit (
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .imm          (imm),
        .busReadData  (busReadData),
        .memOp        (memOp),
        .busAddr      (nextBusAddr),
        .busWriteEn   (nextBusWriteEn),
        .busWriteData (nextBusWriteData),
        .loadEn       (loadEn),
        .loadData     (loadData)
    );

    assign nextRdData = loadEn ? loadData : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid     <= 1'b0;
            rdWriteEn    <= 1'b0;
            rd           <= '0;
            rdData       <= '0;
            jumpEn       <= 1'b0;
            jumpAddr     <= '0;
            busWriteEn   <= 1'b0;
            busAddr      <= '0;
            busWriteData <= '0;
        end else if (accept) begin
            outValid     <= 1'b1;
            rdWriteEn    <= decRdWriteEn;
            rd           <= decRd;
            rdData       <= nextRdData;
            jumpEn       <= nextJumpEn;
            jumpAddr     <= nextJumpAddr;
            busWriteEn   <= nextBusWriteEn;
            busAddr      <= nextBusAddr;
            busWriteData <= nextBusWriteData;
        end else if (outReady) begin
            outValid <= 1'b0; // beat left, nothing new
        end
    end

endmodule

// File: test/idExStage_asserts.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module idExStage_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     inValid,
    input logic                     inReady,
    input logic                     outValid,
    input logic                     outReady,
    input logic                     rdWriteEn,
    input logic [`RV_REG_IDX_W-1:0] rd,
    input logic [`RV_XLEN-1:0]      rdData,
    input logic                     jumpEn,
    input logic [`RV_XLEN-1:0]      jumpAddr,
    input logic                     busWriteEn,
    input logic [`RV_XLEN-1:0]      busAddr,
    input logic [`RV_XLEN-1:0]      busWriteData
);

    localparam int BEAT_W = 3 + `RV_REG_IDX_W + 4 * `RV_XLEN;

    logic [BEAT_W-1:0] beat;
    int                failCount = 0;

    assign beat = {rdWriteEn, rd, rdData, jumpEn, jumpAddr, busWriteEn, busAddr, busWriteData};

    // whole beat cleared, enables included
    resetClears: assert property (@(posedge clk) reset |=> (!outValid && beat == '0))
        else begin
            failCount = failCount + 1;
            $error("output beat not cleared by reset");
        end

    acceptGivesValid: assert property (@(posedge clk) disable iff (reset)
        (inValid && inReady) |=> outValid)
        else begin
            failCount = failCount + 1;
            $error("accepted beat did not reach the output one cycle later");
        end

    // no beat out of nowhere
    emptyStaysEmpty: assert property (@(posedge clk) disable iff (reset)
        (!outValid && !inValid) |=> !outValid)
        else begin
            failCount = failCount + 1;
            $error("output became valid without an accepted beat");
        end

    holdUnderStall: assert property (@(posedge clk) disable iff (reset)
        (outValid && !outReady) |=> (outValid && $stable(beat)))
        else begin
            failCount = failCount + 1;
            $error("output beat changed while stalled");
        end

    readyLowUnderStall: assert property (@(posedge clk) disable iff (reset)
        (outValid && !outReady) |-> !inReady)
        else begin
            failCount = failCount + 1;
            $error("inReady high while output stalled");
        end

endmodule

// File: test/idExStage_tb.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module idExStage_tb;

    localparam int NUM_BEATS  = 400;
    localparam int WAIT_LIMIT = 200;
    localparam int BEAT_W     = 3 + `RV_REG_IDX_W + 4 * `RV_XLEN;

    logic                     clk;
    logic                     reset;
    logic                     inValid;
    logic                     inReady;
    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      inst;
    logic [`RV_XLEN-1:0]      rs1Data;
    logic [`RV_XLEN-1:0]      rs2Data;
    logic [`RV_XLEN-1:0]      busReadData;
    logic                     outValid;
    logic                     outReady;
    logic                     rdWriteEn;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]      rdData;
    logic                     jumpEn;
    logic [`RV_XLEN-1:0]      jumpAddr;
    logic                     busWriteEn;
    logic [`RV_XLEN-1:0]      busAddr;
    logic [`RV_XLEN-1:0]      busWriteData;

    int                seed;
    int                checks;
    int                sentBeats;
    int                valueErrors;
    int                otherErrors;
    int                waitCount;
    logic [BEAT_W-1:0] expected[$];
    logic [BEAT_W-1:0] gotBeat;
    logic [BEAT_W-1:0] expBeat;

    idExStage u_idExStage (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .inReady      (inReady),
        .pc           (pc),
        .inst         (inst),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .busReadData  (busReadData),
        .outValid     (outValid),
        .outReady     (outReady),
        .rdWriteEn    (rdWriteEn),
        .rd           (rd),
        .rdData       (rdData),
        .jumpEn       (jumpEn),
        .jumpAddr     (jumpAddr),
        .busWriteEn   (busWriteEn),
        .busAddr      (busAddr),
        .busWriteData (busWriteData)
    );

    bind idExStage idExStage_asserts u_idExStageAsserts (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .inReady      (inReady),
        .outValid     (outValid),
        .outReady     (outReady),
        .rdWriteEn    (rdWriteEn),
        .rd           (rd),
        .rdData       (rdData),
        .jumpEn       (jumpEn),
        .jumpAddr     (jumpAddr),
        .busWriteEn   (busWriteEn),
        .busAddr      (busAddr),
        .busWriteData (busWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected beat from the base integer ISA rules
    function automatic logic [BEAT_W-1:0] modelBeat(
        input logic [`RV_XLEN-1:0] p,
        input logic [`RV_XLEN-1:0] i,
        input logic [`RV_XLEN-1:0] a,
        input logic [`RV_XLEN-1:0] b,
        input logic [`RV_XLEN-1:0] m
    );
        logic [6:0]          opc;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic [`RV_XLEN-1:0] immI, immS, immB, immU, immJ;
        logic [`RV_XLEN-1:0] opnd, res, jAddr, addr, wData;
        logic                wEn, jEn, sEn, legal;
        logic [7:0]          byteV;
        logic [15:0]         halfV;
        opc   = i[6:0];
        f3    = i[14:12];
        f7    = i[31:25];
        immI  = {{20{i[31]}}, i[31:20]};
        immS  = {{20{i[31]}}, i[31:25], i[11:7]};
        immB  = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        immU  = {i[31:12], 12'b0};
        immJ  = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        res   = '0;
        jAddr = '0;
        addr  = '0;
        wData = '0;
        wEn   = 1'b0;
        jEn   = 1'b0;
        sEn   = 1'b0;
        legal = 1'b1;
        case (opc)
            rv_pkg::opLui: begin
                wEn = 1'b1;
                res = immU;
            end
            rv_pkg::opAuipc: begin
                wEn = 1'b1;
                res = p + immU;
            end
            rv_pkg::opJal, rv_pkg::opJalr: begin
                legal = (opc == rv_pkg::opJal) || (f3 == 3'b000);
                wEn   = legal;
                jEn   = legal;
                if (legal) begin
                    res   = p + `RV_PC_STEP; // link
                    jAddr = (opc == rv_pkg::opJal) ? p + immJ : (a + immI) & ~32'd1;
                end
            end
            rv_pkg::opBranch: begin
                legal = (f3[2:1] != 2'b01);
                case (f3[2:1])
                    2'b00:   jEn = (a == b);
                    2'b10:   jEn = ($signed(a) < $signed(b));
                    default: jEn = (a < b);
                endcase
                jEn   = legal & (jEn ^ f3[0]); // odd funct3 inverts the test
                jAddr = legal ? p + immB : '0;
            end
            rv_pkg::opLoad: begin
                legal = (f3 != 3'b011) && (f3[2:1] != 2'b11);
                if (legal) begin
                    addr  = a + immI;
                    byteV = m[8*addr[1:0] +: 8];
                    halfV = (addr[1:0] == 2'b00) ? m[15:0] : m[31:16];
                    wEn   = 1'b1;
                    case (f3[1:0])
                        2'b00:   res = {{24{byteV[7] & ~f3[2]}}, byteV};
                        2'b01:   res = {{16{halfV[15] & ~f3[2]}}, halfV};
                        default: res = m;
                    endcase
                end
            end
            rv_pkg::opStore: begin
                if (f3 <= 3'b010) begin
                    addr  = a + immS;
                    sEn   = 1'b1;
                    wData = m; // merge into read word
                    case (f3)
                        3'b000: wData[8*addr[1:0] +: 8] = b[7:0];
                        3'b001: begin
                            if (addr[1:0] == 2'b00) begin
                                wData[15:0] = b[15:0];
                            end else begin
                                wData[31:16] = b[15:0];
                            end
                        end
                        default: wData = b;
                    endcase
                end
            end
            rv_pkg::opOpImm, rv_pkg::opOp: begin
                opnd = (opc == rv_pkg::opOp) ? b : immI;
                if (opc == rv_pkg::opOp) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                end else if (f3 == 3'b001) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'b101) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                case (f3)
                    3'b000: res = (opc == rv_pkg::opOp && f7[5]) ? a - opnd : a + opnd;
                    3'b001: res = a << opnd[4:0];
                    3'b010: res = {31'b0, $signed(a) < $signed(opnd)};
                    3'b011: res = {31'b0, a < opnd};
                    3'b100: res = a ^ opnd;
                    3'b101: begin
                        if (f7[5]) begin
                            res = $signed(a) >>> opnd[4:0];
                        end else begin
                            res = a >> opnd[4:0];
                        end
                    end
                    3'b110:  res = a | opnd;
                    default: res = a & opnd;
                endcase
                wEn = legal;
                if (!legal) begin
                    res = '0;
                end
            end
            default: begin
                legal = 1'b0; // nothing enabled
            end
        endcase
        return {wEn, i[11:7], res, jEn, jAddr, sEn, addr, wData};
    endfunction

    function automatic logic [`RV_XLEN-1:0] pickOperand();
        int k;
        k = $unsigned($random(seed)) % 8;
        case (k)
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0000;
            default: return $random(seed);
        endcase
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #2;
        outReady = ($unsigned($random(seed)) % 4 != 0); // random back-pressure
    endtask

    // beat held in the output register is lost
    task automatic pulseReset();
        reset = 1'b1;
        repeat (10) stepCycle();
        sentBeats = sentBeats - expected.size();
        expected.delete();
        reset = 1'b0;
    endtask

    task automatic buildBeat();
        int          sel;
        logic [31:0] r;
        r    = $random(seed);
        sel  = $unsigned($random(seed)) % 10;
        inst = $random(seed);
        case (sel)
            0:       inst[6:0] = rv_pkg::opLui;
            1:       inst[6:0] = rv_pkg::opAuipc;
            2:       inst[6:0] = rv_pkg::opJal;
            3:       inst[6:0] = rv_pkg::opJalr;
            4:       inst[6:0] = rv_pkg::opBranch;
            5:       inst[6:0] = rv_pkg::opLoad;
            6:       inst[6:0] = rv_pkg::opStore;
            7:       inst[6:0] = rv_pkg::opOpImm;
            8:       inst[6:0] = rv_pkg::opOp;
            default: inst[6:0] = 7'b1110011; // csr space, dropped
        endcase
        if ((sel == 7 || sel == 8) && r[1:0] != 2'b00) begin
            inst[31:25] = r[2] ? 7'h20 : 7'h00;
        end
        if (sel == 3 && r[3]) begin
            inst[14:12] = 3'b000;
        end
        pc          = $random(seed);
        pc[1:0]     = 2'b00;
        rs1Data     = pickOperand();
        rs2Data     = (r[5:4] == 2'b00) ? rs1Data : pickOperand(); // equal for branches
        busReadData = $random(seed);
    endtask

    task automatic sendBeat();
        int   tries;
        logic taken;
        buildBeat();
        inValid = 1'b1;
        tries   = 0;
        taken   = 1'b0;
        while (!taken && tries < WAIT_LIMIT) begin
            @(negedge clk);
            taken = inReady;
            stepCycle();
            tries++;
        end
        inValid = 1'b0;
        if (taken) begin
            sentBeats++;
        end else begin
            otherErrors++;
            $display("timeout: input beat was never accepted");
        end
    endtask

    // transfers decided here, half a cycle before their edge
    always @(negedge clk) begin
        if (!reset && outValid && outReady) begin
            gotBeat = {rdWriteEn, rd, rdData, jumpEn, jumpAddr, busWriteEn, busAddr, busWriteData};
            if (expected.size() == 0) begin
                otherErrors++;
                $display("output beat transferred with no accepted input beat behind it");
            end else begin
                expBeat = expected.pop_front();
                checks++;
                assert (gotBeat === expBeat) else begin
                    valueErrors++;
                    $display("[ERROR] %0t ns: output beat %h, expected %h",
                             $time, gotBeat, expBeat);
                end
            end
        end
        if (!reset && inValid && inReady) begin
            expected.push_back(modelBeat(pc, inst, rs1Data, rs2Data, busReadData));
        end
    end

    initial begin
        seed        = 60;
        checks      = 0;
        sentBeats   = 0;
        valueErrors = 0;
        otherErrors = 0;
        reset       = 1'b1;
        inValid     = 1'b0;
        pc          = '0;
        inst        = '0;
        rs1Data     = '0;
        rs2Data     = '0;
        busReadData = '0;
        outReady    = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int n = 0; n < NUM_BEATS && otherErrors == 0; n++) begin
            if (n == NUM_BEATS / 2) begin
                pulseReset(); // outputs loaded, so the clear is visible
            end
            if ($unsigned($random(seed)) % 5 == 0) begin
                stepCycle(); // idle gap
            end
            sendBeat();
        end
        waitCount = 0;
        while ((expected.size() != 0 || outValid) && waitCount < WAIT_LIMIT) begin
            stepCycle();
            waitCount++;
        end
        if (waitCount >= WAIT_LIMIT) begin
            otherErrors++;
            $display("timeout: output beats did not drain");
        end
        if (checks != sentBeats) begin
            otherErrors++;
            $display("checked %0d output beats but sent %0d", checks, sentBeats);
        end
        $display("beats %0d, checks %0d, value errors %0d, other errors %0d, assertion fails %0d",
                 sentBeats, checks, valueErrors, otherErrors,
                 u_idExStage.u_idExStageAsserts.failCount);
        if (valueErrors + otherErrors + u_idExStage.u_idExStageAsserts.failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/rv_pkg.sv
source/instDecoder.sv
source/branchUnit.sv
source/intAlu.sv
source/loadStoreUnit.sv
source/idExStage.sv
test/idExStage_asserts.sv
test/idExStage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the idExStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module idExStage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench prints its summary
output=$(./obj_dir/VidExStage_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
